// File: verilog/arb_defs.svh
`ifndef ARB_DEFS_SVH
`define ARB_DEFS_SVH

// Number of requesters that share the memory request port.
`define ARB_PORTS 4

// Entries in each input queue.
// A requester also starts with this many credits after reset.
`define ARB_QUEUE_DEPTH 4

// Request slots on the memory side, and the reset value of the mux credit counter.
`define ARB_MEM_CREDITS 2

// Request field widths.
`define ARB_ADDR_W 16
`define ARB_DATA_W 16

// Width of the source port number attached to each issued request.
`define ARB_SRC_W 2

`endif

// File: verilog/arb_pkg.sv
`default_nettype none

`include "arb_defs.svh"

package arb_pkg;

    // Memory request opcode.
    // One bit wide, so a request packs into op, address and write data.
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // One request as a requester pushes it into its queue.
    // The op field sits in the top bit, which makes the struct 33 bits.
    typedef struct packed {
        mem_op_e                 op;
        logic [`ARB_ADDR_W-1:0]  addr;
        logic [`ARB_DATA_W-1:0]  wdata;
    } mem_req_t;

    // The request as it leaves on the memory port.
    // The source port rides along so the memory side knows where it came from.
    typedef struct packed {
        mem_req_t               req;
        logic [`ARB_SRC_W-1:0]  src;
    } mem_out_t;

    // Output state of the port mux.
    // MUX_ISSUE holds for exactly one cycle per taken grant.
    typedef enum logic {
        MUX_IDLE  = 1'b0,
        MUX_ISSUE = 1'b1
    } mux_state_e;

endpackage

`default_nettype wire

// File: verilog/round_robin_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "arb_defs.svh"

// Round-robin arbiter built with the mask method.
// Two lowest-index scans run side by side: one over the requests above the
// last granted bit and one over all requests.
module round_robin_arbiter #(
    parameter int WIDTH = `ARB_PORTS
) (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire logic             enable,
    input  wire logic [WIDTH-1:0] request,
    output logic      [WIDTH-1:0] grant
);

    // One-hot copy of the grant that was last taken, or zero after reset.
    logic [WIDTH-1:0] last_grant;

    // Ones in every bit position strictly above the last granted bit.
    logic [WIDTH-1:0] above_last;

    logic [WIDTH-1:0] masked_request;
    logic [WIDTH-1:0] masked_grant;
    logic [WIDTH-1:0] unmasked_grant;

    // Lowest index wins.
    // The scan walks downward so the last hit, the lowest set bit, is kept.
    function automatic logic [WIDTH-1:0] first_set(input logic [WIDTH-1:0] req);
        logic [WIDTH-1:0] onehot;
        onehot = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (req[i]) begin
                onehot    = '0;
                onehot[i] = 1'b1;
            end
        end
        return onehot;
    endfunction

    // Subtracting one from a one-hot value sets all bits below it.
    // Inverting and shifting left leaves only the bits above it.
    // With last_grant at zero the subtraction gives all ones, so the mask is empty.
    assign above_last = (~(last_grant - WIDTH'(1))) << 1;

    assign masked_request = request & above_last;

    assign masked_grant   = first_set(masked_request);
    assign unmasked_grant = first_set(request);

    // A requester above the last winner goes first.
    // When there is none, the search wraps to the lowest requesting index.
    assign grant = (masked_request != '0) ? masked_grant : unmasked_grant;

    // The pointer only moves when the grant is actually taken.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            last_grant <= '0;
        end else if (enable) begin
            last_grant <= grant;
        end
    end

    // At most one requester wins in any cycle.
    assert property (@(posedge clk) disable iff (!rstn) $onehot0(grant))
        else $error("round_robin_arbiter: grant is not one-hot");

    // Only a requesting port may be granted.
    assert property (@(posedge clk) disable iff (!rstn) (grant & ~request) == '0)
        else $error("round_robin_arbiter: grant without request");

endmodule

`default_nettype wire

// File: verilog/req_queue.sv
`timescale 1ns/10ps
`default_nettype none

`include "arb_defs.svh"

// Input queue for one requester.
// Pushes are credited by the requester, and every pop hands one credit back.
module req_queue (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic              push,
    input  wire arb_pkg::mem_req_t push_data,
    input  wire logic              pop,
    output logic                   not_empty,
    output arb_pkg::mem_req_t      head,
    output logic                   credit
);

    import arb_pkg::*;

    localparam int DEPTH = `ARB_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Entry storage.
    // Only the pointers and the count carry control state.
    mem_req_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic full;
    logic do_push;
    logic do_pop;

    // Step a pointer around the ring, which need not be a power of two.
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + PTR_W'(1);
        end
        return nxt;
    endfunction

    assign full      = (count == CNT_W'(DEPTH));
    assign not_empty = (count != '0);

    // The credit protocol keeps pushes away from a full queue.
    // These qualifiers stop a stray push or pop from corrupting the pointers.
    assign do_push = push && !full;
    assign do_pop  = pop && not_empty;

    // The oldest entry is always presented, even before it is granted.
    assign head = mem[rd_ptr];

    // A credit leaves in the same cycle as the pop that frees the slot.
    assign credit = do_pop;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Push and pop together leave the occupancy unchanged.
            if (do_push && !do_pop) begin
                count <= count + CNT_W'(1);
            end else if (do_pop && !do_push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

    // A requester that tracks its credits never pushes into a full queue.
    assert property (@(posedge clk) disable iff (!rstn) push |-> !full)
        else $error("req_queue: push while full, requester credit lost");

    // The mux only pops a queue the arbiter saw as non-empty.
    assert property (@(posedge clk) disable iff (!rstn) pop |-> not_empty)
        else $error("req_queue: pop while empty");

endmodule

`default_nettype wire

// File: verilog/mem_port_mux.sv
`timescale 1ns/10ps
`default_nettype none

`include "arb_defs.svh"

// Drives the memory request port from the granted queue head.
// It also tracks how many request slots the memory side has free.
module mem_port_mux (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic [`ARB_PORTS-1:0]  grant,
    input  wire arb_pkg::mem_req_t      heads [`ARB_PORTS],
    output logic                        take,
    input  wire logic                   mem_credit,
    output logic                        mem_valid,
    output arb_pkg::mem_out_t           mem_req
);

    import arb_pkg::*;

    localparam int PORTS   = `ARB_PORTS;
    localparam int CREDITS = `ARB_MEM_CREDITS;
    localparam int SRC_W   = `ARB_SRC_W;
    localparam int CRED_W  = $clog2(CREDITS + 1);

    // Free request slots on the memory side.
    logic [CRED_W-1:0] credits;

    mux_state_e state;

    // Index of the granted port.
    logic [SRC_W-1:0] sel;

    // Turn the one-hot grant into a port number.
    // The grant is one-hot or zero, so at most one bit matches.
    always_comb begin
        sel = '0;
        for (int i = 0; i < PORTS; i++) begin
            if (grant[i]) begin
                sel = SRC_W'(i);
            end
        end
    end

    // A grant is taken only while a memory slot is free.
    // With no credits the queues simply keep their entries.
    assign take = (grant != '0) && (credits != '0);

    // The issue state lasts exactly the cycle after a take.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= MUX_IDLE;
        end else if (take) begin
            state <= MUX_ISSUE;
        end else begin
            state <= MUX_IDLE;
        end
    end

    assign mem_valid = (state == MUX_ISSUE);

    // Capture the selected head together with its source port.
    // mem_valid qualifies this register, so it holds its value between issues.
    always_ff @(posedge clk) begin
        if (take) begin
            mem_req.req <= heads[sel];
            mem_req.src <= sel;
        end
    end

    // An issue spends a slot and a returned credit frees one.
    // When both happen in the same cycle the count stays put.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credits <= CRED_W'(CREDITS);
        end else begin
            case ({take, mem_credit})
                2'b10: credits <= credits - CRED_W'(1);
                2'b01: credits <= credits + CRED_W'(1);
                default: credits <= credits;
            endcase
        end
    end

    // The memory side never returns more slots than requests it has received.
    assert property (@(posedge clk) disable iff (!rstn) credits <= CRED_W'(CREDITS))
        else $error("mem_port_mux: memory credit returned with no request outstanding");

endmodule

`default_nettype wire

// File: verilog/mem_arbiter_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "arb_defs.svh"

// Shared memory request arbiter.
// Four credited input queues feed a round-robin arbiter.
// The port mux puts one winner per cycle on the memory request port.
module mem_arbiter_top (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic [`ARB_PORTS-1:0]  req_push,
    input  wire arb_pkg::mem_req_t      req_data [`ARB_PORTS],
    output logic      [`ARB_PORTS-1:0]  req_credit,
    output logic                        mem_valid,
    output arb_pkg::mem_out_t           mem_req,
    input  wire logic                   mem_credit
);

    import arb_pkg::*;

    // Non-empty flags of all queues form the arbiter's request vector.
    logic [`ARB_PORTS-1:0] not_empty;

    // One-hot winner, valid in the same cycle as the requests.
    logic [`ARB_PORTS-1:0] grant;

    // High when the mux accepts the grant, which pops the winning queue.
    logic take;

    // Oldest entry of each queue.
    mem_req_t heads [`ARB_PORTS];

    for (genvar p = 0; p < `ARB_PORTS; p++) begin : g_queue
        // Only the granted queue pops, and only when the grant is taken.
        req_queue i_queue (
            .clk       (clk),
            .rstn      (rstn),
            .push      (req_push[p]),
            .push_data (req_data[p]),
            .pop       (take & grant[p]),
            .not_empty (not_empty[p]),
            .head      (heads[p]),
            .credit    (req_credit[p])
        );
    end

    // The pointer advances exactly when the mux takes the grant.
    round_robin_arbiter #(
        .WIDTH (`ARB_PORTS)
    ) i_arbiter (
        .clk     (clk),
        .rstn    (rstn),
        .enable  (take),
        .request (not_empty),
        .grant   (grant)
    );

    mem_port_mux i_mux (
        .clk        (clk),
        .rstn       (rstn),
        .grant      (grant),
        .heads      (heads),
        .take       (take),
        .mem_credit (mem_credit),
        .mem_valid  (mem_valid),
        .mem_req    (mem_req)
    );

endmodule

`default_nettype wire

// File: bench/arb_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "arb_defs.svh"

// Watches both sides of the arbiter and checks every issued request.
// It models the queues, the round-robin pointer and both credit loops.
module arb_checker (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic [`ARB_PORTS-1:0]  req_push,
    input  wire arb_pkg::mem_req_t      req_data [`ARB_PORTS],
    input  wire logic [`ARB_PORTS-1:0]  req_credit,
    input  wire logic                   mem_valid,
    input  wire arb_pkg::mem_out_t      mem_req,
    input  wire logic                   mem_credit,
    output int                          issue_cnt [`ARB_PORTS],
    output int                          outstanding,
    output int                          order_errs,
    output int                          rr_errs,
    output int                          credit_errs,
    output int                          mem_errs,
    output int                          lat_errs
);

    import arb_pkg::*;

    localparam int PORTS = `ARB_PORTS;
    localparam int DEPTH = `ARB_QUEUE_DEPTH;
    localparam int MEMC  = `ARB_MEM_CREDITS;

    // Pushed requests per port, oldest first.
    mem_req_t exp_q [PORTS][$];

    // Model occupancy, and its copy from one edge earlier, when the grant was made.
    int occ [PORTS];
    int seen_occ [PORTS];
    // Credits each requester still holds.
    int avail [PORTS];

    logic [PORTS-1:0] last_credit;
    int               last_src;
    logic             first_issue;
    int               issued;
    int               returned;
    int               returned_lag;
    int               cycle;
    int               total_pushed;
    logic             lat_armed;
    int               lat_due;
    int               lat_src;

    // First non-empty port strictly after the previous winner, wrapping around.
    // Right after reset the search starts at port 0.
    function automatic int next_port();
        int start;
        int idx;
        start = first_issue ? 0 : last_src + 1;
        for (int k = 0; k < PORTS; k++) begin
            idx = (start + k) % PORTS;
            if (seen_occ[idx] > 0) begin
                return idx;
            end
        end
        return -1;
    endfunction

    always @(posedge clk or negedge rstn) begin
        int       src;
        int       expect_src;
        mem_req_t got;
        if (!rstn) begin
            foreach (exp_q[p]) exp_q[p].delete();
            for (int p = 0; p < PORTS; p++) begin
                occ[p]       = 0;
                seen_occ[p]  = 0;
                avail[p]     = DEPTH;
                issue_cnt[p] = 0;
            end
            {order_errs, rr_errs, credit_errs, mem_errs, lat_errs} = '0;
            last_credit  = '0;
            last_src     = 0;
            first_issue  = 1'b1;
            issued       = 0;
            returned     = 0;
            returned_lag = 0;
            outstanding  = 0;
            cycle        = 0;
            total_pushed = 0;
            lat_armed    = 1'b0;
        end else begin
            cycle++;
            src = int'(mem_req.src);
            // Nothing may leave the arbiter before anything was pushed.
            if (total_pushed == 0 && (mem_valid || req_credit != '0)) begin
                $display("** Error at %0t: activity after reset with empty queues", $time);
                lat_errs++;
            end
            // A credit pulse goes with the pop, one cycle ahead of mem_valid.
            if (mem_valid != (last_credit != '0)) begin
                $display("** Error at %0t: mem_valid %0b but credit pulses %b a cycle earlier",
                         $time, mem_valid, last_credit);
                credit_errs++;
            end
            if (mem_valid) begin
                if (last_credit != (PORTS'(1) << src)) begin
                    $display("** Error at %0t: issue from port %0d, credit pulses were %b",
                             $time, src, last_credit);
                    credit_errs++;
                end
                expect_src = next_port();
                if (src != expect_src) begin
                    $display("** Error at %0t: round-robin picked port %0d, expected %0d",
                             $time, src, expect_src);
                    rr_errs++;
                end
                if (exp_q[src].size() == 0) begin
                    $display("** Error at %0t: issue from port %0d with nothing pushed",
                             $time, src);
                    order_errs++;
                end else begin
                    got = exp_q[src].pop_front();
                    if (mem_req.req != got) begin
                        $display("** Error at %0t: port %0d issued %0d/%h/%h, expected %0d/%h/%h",
                                 $time, src, mem_req.req.op, mem_req.req.addr,
                                 mem_req.req.wdata, got.op, got.addr, got.wdata);
                        order_errs++;
                    end
                end
                // The mux saw the credit count of the cycle before the take.
                if (issued - returned_lag >= MEMC) begin
                    $display("** Error at %0t: issue with no memory credit left", $time);
                    mem_errs++;
                end
                issue_cnt[src]++;
                last_src    = src;
                first_issue = 1'b0;
            end
            if (lat_armed && cycle == lat_due) begin
                if (!mem_valid || src != lat_src) begin
                    $display("** Error at %0t: idle push on port %0d not issued 2 cycles later",
                             $time, lat_src);
                    lat_errs++;
                end
                lat_armed = 1'b0;
            end
            returned_lag = returned;
            issued       = issued + int'(mem_valid);
            returned     = returned + int'(mem_credit);
            outstanding  = issued - returned;
            if (outstanding > MEMC || outstanding < 0) begin
                $display("** Error at %0t: %0d requests outstanding at the memory side",
                         $time, outstanding);
                mem_errs++;
            end
            // A lone push into a quiet design must come out two edges later.
            if (!lat_armed && $countones(req_push) == 1 && req_credit == '0 &&
                outstanding == 0 && occ.sum() == 0) begin
                lat_armed = 1'b1;
                lat_due   = cycle + 2;
                lat_src   = $clog2(int'(req_push));
            end
            for (int p = 0; p < PORTS; p++) begin
                seen_occ[p] = occ[p];
                occ[p]      = occ[p] + int'(req_push[p]) - int'(req_credit[p]);
                avail[p]    = avail[p] - int'(req_push[p]) + int'(req_credit[p]);
                if (req_push[p]) begin
                    exp_q[p].push_back(req_data[p]);
                end
                if (avail[p] < 0 || avail[p] > DEPTH) begin
                    $display("** Error at %0t: port %0d holds %0d credits", $time, p, avail[p]);
                    credit_errs++;
                end
            end
            total_pushed = total_pushed + $countones(req_push);
            last_credit  = req_credit;
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "arb_defs.svh"

module tb_mem_arbiter;

    import arb_pkg::*;

    localparam int PORTS = `ARB_PORTS;
    localparam int DEPTH = `ARB_QUEUE_DEPTH;
    localparam int MAX_N = 64;

    logic             clk;
    logic             rstn;
    logic [PORTS-1:0] req_push;
    mem_req_t         req_data [PORTS];
    logic [PORTS-1:0] req_credit;
    logic             mem_valid;
    mem_out_t         mem_req;
    logic             mem_credit;

    // Requests from the stimulus file, in file order.
    int       st_port [MAX_N];
    int       st_idle [MAX_N];
    mem_req_t st_req [MAX_N];
    int       st_n;
    int       exp_issue [PORTS];
    int       limit;
    logic     loaded;

    logic [PORTS-1:0] drv_done;
    int               issue_cnt [PORTS];
    int               outstanding;
    int               order_errs;
    int               rr_errs;
    int               credit_errs;
    int               mem_errs;
    int               lat_errs;

    // Memory model state.
    int          due_q[$];
    logic [31:0] lfsr;
    int          cycle;

    mem_arbiter_top i_dut (
        .clk        (clk),
        .rstn       (rstn),
        .req_push   (req_push),
        .req_data   (req_data),
        .req_credit (req_credit),
        .mem_valid  (mem_valid),
        .mem_req    (mem_req),
        .mem_credit (mem_credit)
    );

    arb_checker i_checker (
        .clk         (clk),
        .rstn        (rstn),
        .req_push    (req_push),
        .req_data    (req_data),
        .req_credit  (req_credit),
        .mem_valid   (mem_valid),
        .mem_req     (mem_req),
        .mem_credit  (mem_credit),
        .issue_cnt   (issue_cnt),
        .outstanding (outstanding),
        .order_errs  (order_errs),
        .rr_errs     (rr_errs),
        .credit_errs (credit_errs),
        .mem_errs    (mem_errs),
        .lat_errs    (lat_errs)
    );

    // Galois LFSR with taps 32, 30, 26 and 25.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic int sum_issues();
        int total;
        total = 0;
        for (int p = 0; p < PORTS; p++) total += issue_cnt[p];
        return total;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // The memory side returns no slot while the design is held in reset.
    initial begin
        rstn       = 1'b0;
        mem_credit = 1'b0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
    end

    initial begin
        int    fd;
        string line;
        int    p;
        int    op;
        int    a;
        int    d;
        int    idl;
        int    idle_sum;
        loaded   = 1'b0;
        st_n     = 0;
        idle_sum = 0;
        for (int i = 0; i < PORTS; i++) exp_issue[i] = 0;
        fd = $fopen("bench/arb_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file bench/arb_stimulus.txt");
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line.getc(0) == "#") continue;
                if (line.getc(0) == "R" &&
                    $sscanf(line, "R %d %d %h %h %d", p, op, a, d, idl) == 5) begin
                    st_port[st_n]      = p;
                    st_idle[st_n]      = idl;
                    st_req[st_n].op    = op[0] ? OP_WRITE : OP_READ;
                    st_req[st_n].addr  = 16'(a);
                    st_req[st_n].wdata = 16'(d);
                    idle_sum           = idle_sum + idl;
                    st_n++;
                end else if (line.getc(0) == "X" && $sscanf(line, "X %d %d", p, d) == 2) begin
                    exp_issue[p] = d;
                end
            end
            $fclose(fd);
            limit  = 10 * (st_n + idle_sum) + 200;
            loaded = 1'b1;
        end
    end

    // One driver per requester, each with its own credit counter.
    for (genvar p = 0; p < PORTS; p++) begin : g_drv
        logic     push_r;
        mem_req_t data_r;
        int       credits;

        assign req_push[p] = push_r;
        assign req_data[p] = data_r;

        always @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                credits <= DEPTH;
            end else begin
                credits <= credits - int'(push_r) + int'(req_credit[p]);
            end
        end

        initial begin
            logic sent;
            push_r      = 1'b0;
            data_r      = '0;
            drv_done[p] = 1'b0;
            wait (loaded && rstn);
            for (int i = 0; i < st_n; i++) begin
                if (st_port[i] == p) begin
                    repeat (st_idle[i]) begin
                        @(posedge clk);
                        push_r <= 1'b0;
                    end
                    // The push still in flight has not reached the counter yet.
                    sent = 1'b0;
                    while (!sent) begin
                        @(posedge clk);
                        if (credits - int'(push_r) > 0) begin
                            push_r <= 1'b1;
                            data_r <= st_req[i];
                            sent = 1'b1;
                        end else begin
                            push_r <= 1'b0;
                        end
                    end
                end
            end
            @(posedge clk);
            push_r <= 1'b0;
            drv_done[p] = 1'b1;
        end
    end

    // The memory side frees the slot of each issued request after 0 to 3 cycles.
    // The cycle count also bounds the run.
    always @(posedge clk) begin
        int delay;
        cycle++;
        if (!rstn) begin
            mem_credit <= 1'b0;
            due_q.delete();
            lfsr = 32'd91777;
        end else begin
            if (mem_valid) begin
                delay = 0;
                repeat (2) begin
                    lfsr  = lfsr_step(lfsr);
                    delay = (delay << 1) | int'(lfsr[0]);
                end
                due_q.push_back(cycle + delay);
            end
            if (due_q.size() > 0 && due_q[0] <= cycle) begin
                mem_credit <= 1'b1;
                void'(due_q.pop_front());
            end else begin
                mem_credit <= 1'b0;
            end
        end
        if (loaded && cycle >= limit) begin
            $display("Timeout: run stopped after %0d cycles with requests still pending", cycle);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Counters from the checker change on the rising edge and settle by the falling one.
    initial begin
        int final_errs;
        int total;
        cycle      = 0;
        final_errs = 0;
        wait (loaded && drv_done == '1);
        while (sum_issues() != st_n || outstanding != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        for (int p = 0; p < PORTS; p++) begin
            if (issue_cnt[p] != exp_issue[p]) begin
                $display("** Error at %0t: port %0d issued %0d requests, expected %0d",
                         $time, p, issue_cnt[p], exp_issue[p]);
                final_errs++;
            end
        end
        total = order_errs + rr_errs + credit_errs + mem_errs + lat_errs + final_errs;
        $display("Errors: order %0d, arbiter %0d, credit %0d, memory %0d, latency %0d, count %0d",
                 order_errs, rr_errs, credit_errs, mem_errs, lat_errs, final_errs);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/arb_stimulus.txt
# Request: R port op(0 read, 1 write) addr(hex) wdata(hex) idle_cycles_before_push
# Expected issue count: X port count
R 1 0 1a00 0000 2
R 0 1 0010 a5a5 12
R 0 1 0012 5a5a 0
R 0 0 0014 0000 0
R 0 1 0016 1234 0
R 0 1 0018 4321 0
R 0 0 001a 0000 0
R 2 1 2000 beef 13
R 2 0 2002 0000 0
R 2 1 2004 cafe 0
R 3 0 3000 0000 12
R 3 1 3002 f00d 0
R 3 1 3004 0bad 1
R 3 0 3006 0000 0
R 3 1 3008 d00d 0
R 1 1 1a02 7777 14
R 1 0 1a04 0000 0
R 1 1 1a06 8888 2
R 2 1 2006 1111 5
R 2 1 2008 2222 0
R 0 0 001c 0000 20
R 1 1 1a08 9999 20
R 2 0 200a 0000 20
R 3 1 300a 3333 20
R 2 1 200c 4444 3
R 3 0 300c 0000 1
R 0 1 001e 6666 2
R 1 1 1a0a abcd 0
X 0 8
X 1 6
X 2 7
X 3 7

// File: sources.f
+incdir+verilog
verilog/arb_pkg.sv
verilog/round_robin_arbiter.sv
verilog/req_queue.sv
verilog/mem_port_mux.sv
verilog/mem_arbiter_top.sv
bench/arb_checker.sv
bench/tb_mem_arbiter.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the arbiter testbench with Verilator from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv --timescale 1ns/10ps \
    -f sources.f --top-module tb_mem_arbiter -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
